//--- sim.f
hw/hpdmc_pkg.sv
hw/hpdmc_ctlif.sv
hw/hpdmc_bankstate.sv
hw/hpdmc_mgmt.sv
hw/hpdmc_datapath.sv
hw/hpdmc.sv
tests/sdram_model.sv
tests/tb_hpdmc.sv

//--- run_sim.sh
#!/bin/sh
# Build the HPDMC testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_hpdmc -f sim.f -o tb_hpdmc \
	> build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_hpdmc > sim.log 2>&1; cat sim.log
grep -q "Done: errors found" sim.log && exit 1
grep -q "Done: no errors" sim.log && exit 0 || exit 1

//--- tests/tb_hpdmc.sv
// Testbench for the HPDMC SDRAM controller driving a behavioral SDRAM on its pads.
`timescale 1ns/1ps
`default_nettype none

module tb_hpdmc;

	localparam int ack_limit = 200;                        // Cycles allowed for one FML ack.

	logic sys_clk;
	logic rst_n;
	logic [13:0] csr_a;
	logic csr_we;
	logic [31:0] csr_di;
	wire [31:0] csr_do;
	logic [24:0] fml_adr;
	logic fml_stb;
	logic fml_we;
	wire fml_ack;
	logic [7:0] fml_sel;
	logic [63:0] fml_di;
	wire [63:0] fml_do;
	wire sdram_cke;
	wire sdram_cs_n;
	wire sdram_ras_n;
	wire sdram_cas_n;
	wire sdram_we_n;
	wire [12:0] sdram_adr;
	wire [1:0] sdram_ba;
	wire [7:0] sdram_dqm;
	wire [63:0] sdram_dq_o;
	wire sdram_dq_oe;
	wire [63:0] sdram_dq_i;
	int model_faults;

	logic [63:0] expected [logic [21:0]];                  // Scoreboard by FML word address.
	logic sw_bypass;                                       // Bypass as last written.
	int errors;
	int checks;
	int tests;
	int failed;
	int err_mark;

	wire rd_cmd = !sdram_cs_n && sdram_ras_n && !sdram_cas_n && sdram_we_n;
	wire wr_cmd = !sdram_cs_n && sdram_ras_n && !sdram_cas_n && !sdram_we_n;
	wire ref_cmd = !sdram_cs_n && !sdram_ras_n && !sdram_cas_n && sdram_we_n;

	hpdmc hpdmc_i (.*);

	sdram_model sdram_i (
		.clk(sys_clk), .cs_n(sdram_cs_n), .ras_n(sdram_ras_n), .cas_n(sdram_cas_n),
		.we_n(sdram_we_n), .ba(sdram_ba), .adr(sdram_adr), .dqm(sdram_dqm),
		.dq_w(sdram_dq_o), .dq_oe(sdram_dq_oe), .dq_r(sdram_dq_i), .faults(model_faults)
	);

	always #10 sys_clk = ~sys_clk;

	// Pad fields a bypass word stands for; strobes are active high in the CSR.
	function automatic logic [18:0] bypass_pads(input logic [31:0] d);
		return {~d[0], ~d[3], ~d[2], ~d[1], d[18:17], d[16:4]};
	endfunction

	function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] nw,
		input logic [7:0] sel);
		logic [63:0] r;
		r = old;
		for (int i = 0; i < 8; i++)
			if (sel[i])
				r[i*8 +: 8] = nw[i*8 +: 8];
		return r;
	endfunction

	function automatic logic [255:0] random_burst();
		logic [255:0] v;
		for (int i = 0; i < 8; i++)
			v[i*32 +: 32] = $urandom;
		return v;
	endfunction

	function automatic logic [24:0] make_adr(input logic [10:0] row, input logic [1:0] ba,
		input logic [8:0] col);
		return {row, ba, col, 3'b000};                     // Row, bank, column, byte.
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~ Protocol assertions
	a_bypass_shown: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(sw_bypass && csr_we && csr_a == 14'd1) |=>
		({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n, sdram_ba, sdram_adr} ==
		bypass_pads($past(csr_di))))
		else begin
			errors++;
			$display("** Error at %0t: bypass command not on the pads", $time);
		end
	a_bypass_once: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(sw_bypass && !sdram_cs_n) |=> sdram_cs_n)
		else begin
			errors++;
			$display("** Error at %0t: bypass command held past one cycle", $time);
		end
	a_write_beat: assert property (@(posedge sys_clk) disable iff (!rst_n)
		wr_cmd |-> (fml_ack && sdram_dq_oe))
		else begin
			errors++;
			$display("** Error at %0t: WRITE without ack and first beat", $time);
		end
	a_read_ack: assert property (@(posedge sys_clk) disable iff (!rst_n)
		$past(rd_cmd, 2) |-> fml_ack)
		else begin
			errors++;
			$display("** Error at %0t: no ack at CAS latency after READ", $time);
		end

	// ~~~~~~~~~~~~~~~~~~~~ Tasks
	task automatic check_word(input logic [63:0] got, input logic [63:0] exp, input string what);
		checks++;
		assert (got == exp)
		else begin
			errors++;
			$display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic abort_run(input string what);
		$display("Timeout: %s never happened", what);
		$display("Done: errors found");
		$finish;
	endtask

	task automatic close_test(input string name);
		tests++;
		if (errors == err_mark) begin
			$display("test %0d %s: pass", tests, name);
		end else begin
			failed++;
			$display("test %0d %s: FAIL with %0d errors", tests, name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	task automatic csr_write(input logic [1:0] word, input logic [31:0] value);
		@(negedge sys_clk);
		csr_a = {12'd0, word};
		csr_we = 1'b1;
		csr_di = value;
		@(negedge sys_clk);
		csr_we = 1'b0;
		if (word == hpdmc_pkg::csr_sys)
			sw_bypass = value[0];
	endtask

	task automatic csr_read(input logic [1:0] word, output logic [31:0] value);
		@(negedge sys_clk);
		csr_a = {12'd0, word};
		@(negedge sys_clk);
		value = csr_do;                                    // Registered readback.
	endtask

	task automatic bypass_issue(input logic [31:0] value);
		csr_write(hpdmc_pkg::csr_bypass, value);
		check_word(64'({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n, sdram_ba, sdram_adr}),
			64'(bypass_pads(value)), "bypass pads");
		@(negedge sys_clk);
		check_word(64'(sdram_cs_n), 64'd1, "pads after bypass");
	endtask

	task automatic wait_ack(input string what);
		int cnt;
		cnt = 0;
		@(negedge sys_clk);
		while (!fml_ack) begin
			cnt++;
			if (cnt > ack_limit)
				abort_run(what);
			@(negedge sys_clk);
		end
	endtask

	task automatic fml_write(input logic [24:0] adr, input logic [255:0] data,
		input logic [31:0] sel);
		logic [21:0] w;
		for (int b = 0; b < 4; b++) begin
			w = adr[24:3] + 22'(b);
			expected[w] = merge_bytes(expected.exists(w) ? expected[w] : '0,
				data[b*64 +: 64], sel[b*8 +: 8]);
		end
		@(negedge sys_clk);
		fml_adr = adr;
		fml_we = 1'b1;
		fml_stb = 1'b1;
		fml_di = data[63:0];
		fml_sel = sel[7:0];
		wait_ack("FML write ack");
		fml_stb = 1'b0;
		for (int b = 1; b < 4; b++) begin
			@(negedge sys_clk);                            // Beat b goes out next edge.
			fml_di = data[b*64 +: 64];
			fml_sel = sel[b*8 +: 8];
		end
	endtask

	task automatic fml_read(input logic [24:0] adr);
		@(negedge sys_clk);
		fml_adr = adr;
		fml_we = 1'b0;
		fml_stb = 1'b1;
		wait_ack("FML read ack");
		fml_stb = 1'b0;
		for (int b = 0; b < 4; b++) begin
			if (b != 0)
				@(negedge sys_clk);
			check_word(fml_do, expected[adr[24:3] + 22'(b)], "read beat");
		end
	endtask

	task automatic wait_refresh(input int limit);
		int cnt;
		cnt = 0;
		@(negedge sys_clk);
		while (!ref_cmd) begin
			cnt++;
			if (cnt > limit)
				abort_run("auto-refresh on the pads");
			@(negedge sys_clk);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~ Test sequence
	initial begin
		logic [31:0] rd;
		logic [19:0] tim;
		logic [24:0] adrs [20];
		logic [1:0] ba;
		logic [10:0] row;
		logic [24:0] a;
		void'($urandom(32'h5586));
		sys_clk = 1'b0;
		rst_n = 1'b0;
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		fml_adr = '0;
		fml_stb = 1'b0;
		fml_we = 1'b0;
		fml_sel = '0;
		fml_di = '0;
		sw_bypass = 1'b1;
		errors = 0;
		checks = 0;
		tests = 0;
		failed = 0;
		err_mark = 0;
		ba = '0;
		row = '0;
		repeat (3) @(negedge sys_clk);
		rst_n = 1'b1;

		// Reset state.
		check_word(64'({sdram_cs_n, sdram_cke, sdram_dq_oe, fml_ack}), 64'b1000,
			"pads after reset");
		csr_read(hpdmc_pkg::csr_sys, rd);
		check_word(64'(rd), 64'h3, "csr_sys after reset");  // Bypass and reset, no CKE.
		close_test("reset state");

		// Init sequence through bypass.
		csr_write(hpdmc_pkg::csr_sys, 32'h5);              // CKE up, still bypass.
		check_word(64'(sdram_cke), 64'd1, "CKE pad after enable");
		bypass_issue(32'h0000_400B);                       // Precharge all.
		bypass_issue(32'h0000_000D);                       // Auto-refresh.
		bypass_issue(32'h0000_000D);
		bypass_issue(32'h0000_022F);                       // Mode: CL 2, burst 4.
		tim = {3'd2, 3'd2, 4'd6, 10'd600};
		csr_write(hpdmc_pkg::csr_timing, {12'd0, tim});
		csr_read(hpdmc_pkg::csr_timing, rd);
		check_word(64'(rd), 64'(tim), "csr_timing readback");
		csr_write(hpdmc_pkg::csr_sys, 32'h4);              // Hand pads to the FSM.
		csr_read(hpdmc_pkg::csr_sys, rd);
		check_word(64'(rd), 64'h4, "csr_sys after init");
		close_test("bypass init");

		// Masked write over a full write.
		a = make_adr(11'd5, 2'd1, 9'd8);
		fml_write(a, random_burst(), 32'hFFFF_FFFF);
		fml_write(a, random_burst(), $urandom);
		fml_read(a);
		close_test("masked write");

		// Random traffic; every third access reuses the previous page.
		for (int i = 0; i < 20; i++) begin
			if (i % 3 != 2) begin
				ba = 2'($urandom);
				row = 11'($urandom);
			end
			adrs[i] = make_adr(row, ba, {7'($urandom), 2'b00});
			fml_write(adrs[i], random_burst(), 32'hFFFF_FFFF);
		end
		for (int i = 0; i < 20; i++)
			fml_read(adrs[i]);
		close_test("random traffic");

		// Refresh at a short interval.
		tim = {3'd2, 3'd2, 4'd6, 10'd40};
		csr_write(hpdmc_pkg::csr_timing, {12'd0, tim});
		a = make_adr(11'd77, 2'd2, 9'd100);
		fml_write(a, random_burst(), 32'hFFFF_FFFF);
		wait_refresh(700);                                 // Old interval may still run.
		wait_refresh(40 + 20);
		fml_read(a);
		close_test("refresh");

		checks++;
		assert (model_faults == 0)
		else begin
			errors++;
			$display("SDRAM model saw %0d protocol faults", model_faults);
		end
		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/sdram_model.sv
// Behavioral SDR SDRAM with four banks, open-row tracking, CAS latency and masked bursts of four.
`timescale 1ns/1ps
`default_nettype none

module sdram_model (
	input wire clk,
	input wire cs_n,
	input wire ras_n,
	input wire cas_n,
	input wire we_n,
	input wire [1:0] ba,
	input wire [12:0] adr,
	input wire [7:0] dqm,
	input wire [63:0] dq_w,                                // Controller to memory.
	input wire dq_oe,
	output logic [63:0] dq_r,                              // Memory to controller.
	output int faults
);

	logic [63:0] mem [logic [23:0]];                       // Keyed by {bank, row, column}.
	logic [12:0] open_row [4];
	logic [3:0] open_bank;
	logic [12:0] mode;                                     // Mode register, CL in bits 6:4.
	logic [23:0] wr_key;
	logic [23:0] rd_key;
	int wr_left;
	int rd_left;
	int rd_wait;

	// Unwritten words return a pattern built from the whole address.
	function automatic logic [63:0] fill(input logic [23:0] key);
		return {8'hA5, key, 8'h3C, ~key};
	endfunction

	function automatic logic [63:0] peek(input logic [23:0] key);
		return mem.exists(key) ? mem[key] : fill(key);
	endfunction

	task automatic fault(input string what);
		faults++;
		$display("sdram_model: %s at %0t", what, $time);
	endtask

	task automatic store(input logic [23:0] key);
		logic [63:0] word;
		word = peek(key);
		for (int i = 0; i < 8; i++)
			if (!dqm[i])
				word[i*8 +: 8] = dq_w[i*8 +: 8];          // Masked bytes keep old data.
		mem[key] = word;
		if (!dq_oe)
			fault("write beat arrived without output enable");
	endtask

	initial begin
		faults = 0;
		open_bank = '0;
		mode = '0;
		dq_r = '0;
		wr_key = '0;
		rd_key = '0;
		wr_left = 0;
		rd_left = 0;
		rd_wait = 0;
	end

	always @(posedge clk) begin
		logic [23:0] key;
		// ~~~~~~~~~~~~~~~~~~~~ Bursts in flight
		if (wr_left > 0) begin
			store(wr_key);                                 // Sequential columns.
			wr_key = wr_key + 24'd1;
			wr_left--;
		end
		if (rd_left > 0 && rd_wait > 1) begin
			rd_wait--;                                     // Still inside CAS latency.
		end else if (rd_left > 0) begin
			dq_r <= peek(rd_key);
			rd_key = rd_key + 24'd1;
			rd_left--;
		end else begin
			dq_r <= '0;
		end

		// ~~~~~~~~~~~~~~~~~~~~ Commands
		key = {ba, open_row[ba], adr[8:0]};
		if (!cs_n) begin
			case ({ras_n, cas_n, we_n})
				3'b011: begin
					if (open_bank[ba])
						fault("activate to a bank with an open row");
					open_bank[ba] = 1'b1;
					open_row[ba] = adr;
				end
				3'b010: begin
					if (adr[10])
						open_bank = '0;                    // Precharge all.
					else
						open_bank[ba] = 1'b0;
				end
				3'b001: if (open_bank != '0) fault("refresh while a bank is open");
				3'b000: mode = adr;                        // Load mode register.
				3'b101: begin
					if (!open_bank[ba])
						fault("read to a closed bank");
					rd_key = key;
					rd_left = 4;
					rd_wait = int'(mode[6:4]) - 1;
				end
				3'b100: begin
					if (!open_bank[ba])
						fault("write to a closed bank");
					store(key);                            // First beat rides with WRITE.
					wr_key = key + 24'd1;
					wr_left = 3;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/hpdmc.sv
// HPDMC SDRAM controller top level joining CSR, FML and the SDR pads.
`timescale 1ns/1ps
`default_nettype none

module hpdmc #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input wire sys_clk,
	input wire rst_n,

	input wire [13:0] csr_a,
	input wire csr_we,
	input wire [31:0] csr_di,
	output wire [31:0] csr_do,

	input wire [hpdmc_pkg::fml_depth-1:0] fml_adr,
	input wire fml_stb,
	input wire fml_we,
	output wire fml_ack,
	input wire [7:0] fml_sel,
	input wire [63:0] fml_di,
	output wire [63:0] fml_do,

	output wire sdram_cke,
	output wire sdram_cs_n,
	output wire sdram_ras_n,
	output wire sdram_cas_n,
	output wire sdram_we_n,
	output wire [12:0] sdram_adr,
	output wire [1:0] sdram_ba,
	output wire [7:0] sdram_dqm,
	output wire [63:0] sdram_dq_o,
	output wire sdram_dq_oe,
	input wire [63:0] sdram_dq_i
);

	hpdmc_pkg::fml_req_t req;
	hpdmc_pkg::page_t page;
	hpdmc_pkg::timing_t timing;
	hpdmc_pkg::sdram_cmd_t bypass_cmd;
	hpdmc_pkg::sdram_cmd_t mgmt_cmd;
	hpdmc_pkg::sdram_cmd_t pad_cmd;
	logic bypass;
	logic sdram_rst;
	logic bypass_cmd_valid;
	logic bank_open;
	logic bank_close;
	logic close_all;
	logic rd_issue;
	logic wr_issue;
	logic burst_busy;

	// ~~~~~~~~~~~~~~~~~~~~ Request decode
	// Column lowest, then bank, then row.
	assign req = '{
		we: fml_we,
		ba: fml_adr[hpdmc_pkg::col_lsb + hpdmc_pkg::col_bits +: hpdmc_pkg::bank_bits],
		row: {{(hpdmc_pkg::row_bits - hpdmc_pkg::row_used){1'b0}},
			fml_adr[hpdmc_pkg::fml_depth-1:hpdmc_pkg::row_lsb]},
		col: fml_adr[hpdmc_pkg::col_lsb +: hpdmc_pkg::col_bits]
	};

	// ~~~~~~~~~~~~~~~~~~~~ Pad command mux
	assign pad_cmd = !bypass ? mgmt_cmd :
		(bypass_cmd_valid ? bypass_cmd : hpdmc_pkg::cmd_idle); // Software owns pads in bypass.
	assign sdram_cs_n = pad_cmd.cs_n;
	assign sdram_ras_n = pad_cmd.ras_n;
	assign sdram_cas_n = pad_cmd.cas_n;
	assign sdram_we_n = pad_cmd.we_n;
	assign sdram_adr = pad_cmd.adr;
	assign sdram_ba = pad_cmd.ba;

	hpdmc_ctlif #(
		.csr_addr(csr_addr)
	) ctlif_i (
		.sys_clk(sys_clk),
		.rst_n(rst_n),
		.csr_a(csr_a),
		.csr_we(csr_we),
		.csr_di(csr_di),
		.csr_do(csr_do),
		.bypass(bypass),
		.sdram_rst(sdram_rst),
		.cke(sdram_cke),
		.bypass_cmd_valid(bypass_cmd_valid),
		.bypass_cmd(bypass_cmd),
		.timing(timing)
	);

	hpdmc_bankstate bankstate_i (
		.sys_clk(sys_clk),
		.rst_n(rst_n),
		.req(req),
		.page(page),
		.bank_open(bank_open),
		.bank_close(bank_close),
		.close_all(close_all)
	);

	hpdmc_mgmt mgmt_i (
		.sys_clk(sys_clk),
		.rst_n(rst_n),
		.bypass(bypass),
		.sdram_rst(sdram_rst),
		.timing(timing),
		.fml_stb(fml_stb),
		.req(req),
		.page(page),
		.cmd(mgmt_cmd),
		.bank_open(bank_open),
		.bank_close(bank_close),
		.close_all(close_all),
		.rd_issue(rd_issue),
		.wr_issue(wr_issue),
		.burst_busy(burst_busy)
	);

	hpdmc_datapath datapath_i (
		.sys_clk(sys_clk),
		.rst_n(rst_n),
		.rd_issue(rd_issue),
		.wr_issue(wr_issue),
		.fml_di(fml_di),
		.fml_sel(fml_sel),
		.fml_do(fml_do),
		.fml_ack(fml_ack),
		.sdram_dq_o(sdram_dq_o),
		.sdram_dq_oe(sdram_dq_oe),
		.sdram_dqm(sdram_dqm),
		.sdram_dq_i(sdram_dq_i),
		.burst_busy(burst_busy)
	);

endmodule

`default_nettype wire

//--- hw/hpdmc_datapath.sv
// HPDMC data path for masked write beats, CAS-latency read timing and FML acknowledge.
`timescale 1ns/1ps
`default_nettype none

module hpdmc_datapath (
	input wire sys_clk,
	input wire rst_n,
	input wire rd_issue,
	input wire wr_issue,
	input wire [63:0] fml_di,
	input wire [7:0] fml_sel,
	output logic [63:0] fml_do,
	output logic fml_ack,
	output logic [63:0] sdram_dq_o,
	output logic sdram_dq_oe,
	output logic [7:0] sdram_dqm,
	input wire [63:0] sdram_dq_i,
	output logic burst_busy                                // Holds the FSM in its wait state.
);

	logic [hpdmc_pkg::beat_bits-1:0] wr_left;              // Write beats after the first.
	logic [hpdmc_pkg::beat_bits-1:0] rd_left;              // Read beats after the first.
	logic [hpdmc_pkg::cas_latency-1:0] rd_pipe;            // READ delayed to first data.
	logic rd_first;
	logic rd_valid;

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			wr_left <= '0;
			rd_left <= '0;
			rd_pipe <= '0;
		end else begin
			rd_pipe <= {rd_pipe[hpdmc_pkg::cas_latency-2:0], rd_issue};
			if (wr_issue)
				wr_left <= hpdmc_pkg::beat_last;
			else if (wr_left != '0)
				wr_left <= wr_left - 1'b1;
			if (rd_first)
				rd_left <= hpdmc_pkg::beat_last;
			else if (rd_left != '0)
				rd_left <= rd_left - 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~ Write
	// First beat leaves with the WRITE command.
	assign sdram_dq_oe = wr_issue | (wr_left != '0);
	assign sdram_dq_o = fml_di;
	assign sdram_dqm = sdram_dq_oe ? ~fml_sel : '0;       // Unselected bytes masked.

	// ~~~~~~~~~~~~~~~~~~~~ Read
	assign rd_first = rd_pipe[hpdmc_pkg::cas_latency-1];  // First data at the pads.
	assign rd_valid = rd_first | (rd_left != '0);
	assign fml_do = rd_valid ? sdram_dq_i : '0;

	assign fml_ack = wr_issue | rd_first;
	assign burst_busy = sdram_dq_oe | rd_issue | (|rd_pipe) | rd_valid;

endmodule

`default_nettype wire

//--- hw/hpdmc_mgmt.sv
// HPDMC control FSM sequencing precharge, activate, read, write and auto-refresh commands.
`timescale 1ns/1ps
`default_nettype none

module hpdmc_mgmt (
	input wire sys_clk,
	input wire rst_n,
	input wire bypass,
	input wire sdram_rst,
	input wire hpdmc_pkg::timing_t timing,
	input wire fml_stb,
	input wire hpdmc_pkg::fml_req_t req,
	input wire hpdmc_pkg::page_t page,
	output hpdmc_pkg::sdram_cmd_t cmd,                     // Registered pad command.
	output logic bank_open,
	output logic bank_close,
	output logic close_all,
	output logic rd_issue,                                 // High with READ on the pads.
	output logic wr_issue,                                 // High with WRITE on the pads.
	input wire burst_busy
);

	typedef enum logic [2:0] {
		s_idle,
		s_pre,
		s_act,
		s_rw,
		s_wait,
		s_ref
	} state_t;

	state_t state;
	logic [3:0] timer;                                     // Shared t_rp, t_rcd, t_rfc count.
	logic [9:0] refi_cnt;
	logic ref_pending;                                     // Refresh interval elapsed.
	logic pre_all;                                         // Last PRE closed every bank.
	logic halted;
	logic [hpdmc_pkg::row_bits-1:0] col_adr;

	assign halted = bypass | sdram_rst;
	assign col_adr = {{(hpdmc_pkg::row_bits - hpdmc_pkg::col_bits){1'b0}}, req.col}; // A10 low.

	function automatic hpdmc_pkg::sdram_cmd_t mk_cmd(
		input logic [2:0] code,
		input logic [hpdmc_pkg::bank_bits-1:0] ba,
		input logic [hpdmc_pkg::row_bits-1:0] adr
	);
		hpdmc_pkg::sdram_cmd_t c;
		c.cs_n = 1'b0;
		{c.ras_n, c.cas_n, c.we_n} = code;
		c.ba = ba;
		c.adr = adr;
		return c;
	endfunction

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			state <= s_idle;
			timer <= '0;
			refi_cnt <= '0;
			ref_pending <= 1'b0;
			pre_all <= 1'b0;
			cmd <= hpdmc_pkg::cmd_idle;
			bank_open <= 1'b0;
			bank_close <= 1'b0;
			close_all <= 1'b0;
			rd_issue <= 1'b0;
			wr_issue <= 1'b0;
		end else begin
			cmd <= hpdmc_pkg::cmd_idle;                    // Deselect unless a command goes out.
			bank_open <= 1'b0;
			bank_close <= 1'b0;
			close_all <= halted;                           // Software owns the banks.
			rd_issue <= 1'b0;
			wr_issue <= 1'b0;
			if (timer != '0)
				timer <= timer - 1'b1;

			case (state)
				s_idle: begin
					if (!halted && ref_pending) begin
						cmd <= mk_cmd(hpdmc_pkg::cmd_pre, '0, hpdmc_pkg::adr_a10);
						close_all <= 1'b1;
						pre_all <= 1'b1;
						timer <= {1'b0, timing.t_rp};
						state <= s_pre;
					end else if (!halted && fml_stb) begin
						case (page)
							hpdmc_pkg::page_hit: state <= s_rw;
							hpdmc_pkg::page_miss: begin
								cmd <= mk_cmd(hpdmc_pkg::cmd_pre, req.ba, '0);
								bank_close <= 1'b1;
								timer <= {1'b0, timing.t_rp};
								state <= s_pre;
							end
							default: begin
								cmd <= mk_cmd(hpdmc_pkg::cmd_act, req.ba, req.row);
								bank_open <= 1'b1;
								timer <= {1'b0, timing.t_rcd};
								state <= s_act;
							end
						endcase
					end
				end
				s_pre: begin
					if (timer == '0 && pre_all) begin
						cmd <= mk_cmd(hpdmc_pkg::cmd_ref, '0, '0);
						pre_all <= 1'b0;
						ref_pending <= 1'b0;
						timer <= timing.t_rfc;
						state <= s_ref;
					end else if (timer == '0) begin
						state <= s_idle;                   // Idle opens the new row.
					end
				end
				s_act: if (timer == '0) state <= s_rw;
				s_rw: begin
					cmd <= mk_cmd(req.we ? hpdmc_pkg::cmd_write : hpdmc_pkg::cmd_read,
						req.ba, col_adr);
					wr_issue <= req.we;
					rd_issue <= ~req.we;
					state <= s_wait;
				end
				s_wait: if (!burst_busy) state <= s_idle;  // Datapath ends the burst.
				s_ref: if (timer == '0) state <= s_idle;
				default: state <= s_idle;
			endcase

			// ~~~~~~~~~~~~~~~~~~~~ Refresh interval
			if (halted) begin
				refi_cnt <= timing.t_refi;
				ref_pending <= 1'b0;
			end else if (refi_cnt == '0) begin
				refi_cnt <= timing.t_refi;
				ref_pending <= 1'b1;
			end else begin
				refi_cnt <= refi_cnt - 1'b1;
			end
		end
	end

	// Column commands only go to a row the bank table reports open.
	a_rw_on_hit: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(rd_issue || wr_issue) |-> $past(page == hpdmc_pkg::page_hit))
		else $error("READ or WRITE issued without a page hit");

endmodule

`default_nettype wire

//--- hw/hpdmc_bankstate.sv
// HPDMC open-row table per bank with page hit, miss or empty lookup for the pending request.
`timescale 1ns/1ps
`default_nettype none

module hpdmc_bankstate (
	input wire sys_clk,
	input wire rst_n,
	input wire hpdmc_pkg::fml_req_t req,
	output hpdmc_pkg::page_t page,
	input wire bank_open,                                  // ACT issued to req.ba.
	input wire bank_close,                                 // PRE issued to req.ba.
	input wire close_all                                   // PRE all, or controller halted.
);

	logic [hpdmc_pkg::bank_count-1:0] valid;               // Bank holds an open row.
	logic [hpdmc_pkg::row_bits-1:0] open_row [hpdmc_pkg::bank_count];

	always_comb begin
		if (!valid[req.ba])
			page = hpdmc_pkg::page_empty;
		else if (open_row[req.ba] == req.row)
			page = hpdmc_pkg::page_hit;
		else
			page = hpdmc_pkg::page_miss;
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n || close_all)
			valid <= '0;
		else if (bank_open)
			valid[req.ba] <= 1'b1;
		else if (bank_close)
			valid[req.ba] <= 1'b0;
	end

	// Row address latched on ACT.
	always_ff @(posedge sys_clk) begin
		if (bank_open)
			open_row[req.ba] <= req.row;
	end

	// The control FSM must precharge before opening a bank again.
	a_open_free_bank: assert property (@(posedge sys_clk) disable iff (!rst_n)
		bank_open |-> !valid[req.ba])
		else $error("activate issued to a bank that already has an open row");

endmodule

`default_nettype wire

//--- hw/hpdmc_ctlif.sv
// HPDMC CSR block holding system control, the bypass command strobe and SDRAM timing.
`timescale 1ns/1ps
`default_nettype none

module hpdmc_ctlif #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input wire sys_clk,
	input wire rst_n,
	input wire [13:0] csr_a,
	input wire csr_we,
	input wire [31:0] csr_di,
	output logic [31:0] csr_do,
	output logic bypass,                                   // Pads belong to software.
	output logic sdram_rst,                                // Holds the controller FSM idle.
	output logic cke,
	output logic bypass_cmd_valid,                         // One cycle per CSR write.
	output hpdmc_pkg::sdram_cmd_t bypass_cmd,
	output hpdmc_pkg::timing_t timing
);

	logic sel;
	logic [1:0] word;

	assign sel = csr_a[13:10] == csr_addr;                 // Block select.
	assign word = csr_a[1:0];

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			bypass <= 1'b1;                                // Boot code runs the init sequence.
			sdram_rst <= 1'b1;
			cke <= 1'b0;
			bypass_cmd_valid <= 1'b0;
			bypass_cmd <= hpdmc_pkg::cmd_idle;
			timing <= hpdmc_pkg::timing_rst;
			csr_do <= '0;
		end else begin
			bypass_cmd_valid <= 1'b0;
			if (sel && csr_we) begin
				case (word)
					hpdmc_pkg::csr_sys: begin
						bypass <= csr_di[0];
						sdram_rst <= csr_di[1];
						cke <= csr_di[2];
					end
					hpdmc_pkg::csr_bypass: begin
						// Strobe bits are active high here.
						bypass_cmd_valid <= 1'b1;
						bypass_cmd.cs_n <= ~csr_di[0];
						bypass_cmd.we_n <= ~csr_di[1];
						bypass_cmd.cas_n <= ~csr_di[2];
						bypass_cmd.ras_n <= ~csr_di[3];
						bypass_cmd.adr <= csr_di[16:4];
						bypass_cmd.ba <= csr_di[18:17];
					end
					hpdmc_pkg::csr_timing: timing <= hpdmc_pkg::timing_t'(csr_di[19:0]);
					default: ;
				endcase
			end

			// ~~~~~~~~~~~~~~~~~~~~ Readback
			csr_do <= '0;                                  // Zero outside the block.
			if (sel) begin
				case (word)
					hpdmc_pkg::csr_sys: csr_do <= {29'd0, cke, sdram_rst, bypass};
					hpdmc_pkg::csr_bypass: csr_do <= {13'd0, bypass_cmd.ba, bypass_cmd.adr,
						~bypass_cmd.ras_n, ~bypass_cmd.cas_n, ~bypass_cmd.we_n,
						~bypass_cmd.cs_n};
					hpdmc_pkg::csr_timing: csr_do <= {12'd0, timing};
					default: ;
				endcase
			end
		end
	end

	// A bypass command owns the pads for a single cycle.
	a_bypass_pulse: assert property (@(posedge sys_clk) disable iff (!rst_n)
		bypass_cmd_valid |=> !bypass_cmd_valid)
		else $error("bypass command strobe held longer than one cycle");

endmodule

`default_nettype wire

//--- hw/hpdmc_pkg.sv
// HPDMC shared definitions for geometry, CSR map, SDRAM commands and request types.
`default_nettype none

package hpdmc_pkg;

	// ~~~~~~~~~~~~~~~~~~~~ Geometry
	localparam int fml_depth = 25;                         // Byte address width of FML.
	localparam int bank_bits = 2;
	localparam int row_bits = 13;
	localparam int col_bits = 9;                           // Columns count 64-bit words.
	localparam int burst_len = 4;                          // Beats per FML burst.
	localparam int cas_latency = 2;                        // READ to data at the pads.
	localparam int bank_count = 1 << bank_bits;
	localparam int beat_bits = $clog2(burst_len);
	localparam logic [beat_bits-1:0] beat_last = beat_bits'(burst_len - 1);
	localparam int col_lsb = 3;                            // Byte offset within a word.
	localparam int row_lsb = col_lsb + col_bits + bank_bits;
	localparam int row_used = fml_depth - row_lsb;         // Row bits the FML space reaches.

	// ~~~~~~~~~~~~~~~~~~~~ CSR map
	localparam logic [1:0] csr_sys = 2'd0;                 // Bypass, reset, CKE.
	localparam logic [1:0] csr_bypass = 2'd1;              // Raw pad command.
	localparam logic [1:0] csr_timing = 2'd2;              // Packed timing_t.

	// ~~~~~~~~~~~~~~~~~~~~ Commands
	// Encodings are {ras_n, cas_n, we_n}.
	localparam logic [2:0] cmd_nop = 3'b111;
	localparam logic [2:0] cmd_act = 3'b011;
	localparam logic [2:0] cmd_read = 3'b101;
	localparam logic [2:0] cmd_write = 3'b100;
	localparam logic [2:0] cmd_pre = 3'b010;
	localparam logic [2:0] cmd_ref = 3'b001;
	localparam logic [row_bits-1:0] adr_a10 = 13'h0400;   // PRE on all banks.

	typedef struct packed {
		logic cs_n;
		logic ras_n;
		logic cas_n;
		logic we_n;
		logic [bank_bits-1:0] ba;
		logic [row_bits-1:0] adr;
	} sdram_cmd_t;

	typedef struct packed {
		logic [2:0] t_rp;                                  // Precharge to activate.
		logic [2:0] t_rcd;                                 // Activate to read or write.
		logic [3:0] t_rfc;                                 // Refresh cycle time.
		logic [9:0] t_refi;                                // Refresh interval.
	} timing_t;

	typedef struct packed {
		logic we;
		logic [bank_bits-1:0] ba;
		logic [row_bits-1:0] row;
		logic [col_bits-1:0] col;
	} fml_req_t;

	typedef enum logic [1:0] {
		page_hit,
		page_miss,
		page_empty
	} page_t;

	// Deselected NOP.
	localparam sdram_cmd_t cmd_idle = {1'b1, cmd_nop, {bank_bits{1'b0}}, {row_bits{1'b0}}};
	localparam timing_t timing_rst = '{t_rp: 3'd3, t_rcd: 3'd3, t_rfc: 4'd8, t_refi: 10'd780};

endpackage

`default_nettype wire
